// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_id_stage
BUILD_DIR ?= build
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+97
FLIST     ?= id_stage.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-$(BIN) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '>>> PASS' $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/id_pkg.sv ====
`include "id_stage_config.svh"

`default_nettype none

package id_pkg;

	// major opcodes kept from RV32I
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} f3_branch_e;

	typedef enum logic [2:0] {
		F3_LB  = 3'b000,
		F3_LH  = 3'b001,
		F3_LW  = 3'b010,
		F3_LBU = 3'b100,
		F3_LHU = 3'b101
	} f3_load_e;

	typedef enum logic [2:0] {
		F3_SB = 3'b000,
		F3_SH = 3'b001,
		F3_SW = 3'b010
	} f3_store_e;

	// shared by OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_SLTU    = 3'b011,
		F3_XOR     = 3'b100,
		F3_SR      = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} f3_alu_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
	} alu_op_e;

	typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} format_e;	// R is zero

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
	} branch_e;

	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

	// record handed to execute, all zero is a bubble
	typedef struct packed {
		logic			is_valid;
		format_e		format;
		alu_op_e		alu_op;
		logic			alu_src;	// operand b is the immediate
		logic			is_branch;
		branch_e		branch_type;
		logic			mem_rd;
		logic			mem_wr;
		mem_size_e		mem_size;
		logic			mem_unsigned;
		logic			rf_wr;
		logic [`REG_AW-1:0]	rd_addr;
		logic [`XLEN-1:0]	pc;
		logic [`XLEN-1:0]	rs1_data;
		logic [`XLEN-1:0]	rs2_data;
		logic [`XLEN-1:0]	imm;
	} id_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/id_stage.sv ====
`include "id_stage_config.svh"

`default_nettype none

module id_stage (
	input  wire logic			clk,
	input  wire logic			rst_n,
	input  wire logic [`ILEN-1:0]	i_if_instr,
	input  wire logic			i_if_valid,
	input  wire logic [`XLEN-1:0]	i_if_pc,
	input  wire logic			i_ex_ready,
	input  wire logic			i_ex_branch_taken,
	input  wire logic			i_ex_jump_taken,
	input  wire logic			i_wb_wr_en,
	input  wire logic [`REG_AW-1:0]	i_wb_wr_addr,
	input  wire logic [`XLEN-1:0]	i_wb_wr_data,
	output logic			o_id_ready,
	output id_pkg::id_ctrl_t		o_id_ctrl
);

	import id_pkg::*;

	logic			dec_valid;
	id_ctrl_t		dec_ctrl;
	id_ctrl_t		next_ctrl;
	logic [`XLEN-1:0]	rs1_data;
	logic [`XLEN-1:0]	rs2_data;
	logic [`XLEN-1:0]	imm;

	// a taken redirect squashes whatever fetch presents
	assign dec_valid = i_if_valid & ~i_ex_branch_taken & ~i_ex_jump_taken;

	instr_decoder u_decoder (
		.i_instr	(i_if_instr),
		.i_valid	(dec_valid),
		.o_ctrl		(dec_ctrl)
	);

	imm_gen u_imm_gen (
		.i_instr	(i_if_instr),
		.i_format	(dec_ctrl.format),
		.o_imm		(imm)
	);

	regfile_2r1w u_regfile (
		.clk		(clk),
		.i_raddr_a	(i_if_instr[`RNG_RS1]),
		.i_raddr_b	(i_if_instr[`RNG_RS2]),
		.i_wen		(i_wb_wr_en),
		.i_waddr	(i_wb_wr_addr),
		.i_wdata	(i_wb_wr_data),
		.o_rdata_a	(rs1_data),
		.o_rdata_b	(rs2_data)
	);

	always_comb begin
		next_ctrl = dec_ctrl;
		if (dec_ctrl.is_valid) begin	// bubble keeps data fields zero
			next_ctrl.pc = i_if_pc;
			next_ctrl.rs1_data = rs1_data;
			next_ctrl.rs2_data = rs2_data;
			next_ctrl.imm = imm;
		end
	end

	assign o_id_ready = i_ex_ready;	// stall straight from execute

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_id_ctrl <= '0;
		end else if (o_id_ready) begin
			o_id_ctrl <= next_ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`include "id_stage_config.svh"

`default_nettype none

module imm_gen (
	input  wire logic [`ILEN-1:0]	i_instr,
	input  wire id_pkg::format_e	i_format,
	output logic [`XLEN-1:0]		o_imm
);

	import id_pkg::*;

	logic sgn;

	assign sgn = i_instr[31];	// sign bit for every format

	always_comb begin
		case (i_format)
			FMT_I: o_imm = {{(`XLEN-12){sgn}}, i_instr[31:20]};
			FMT_S: o_imm = {{(`XLEN-12){sgn}}, i_instr[31:25], i_instr[11:7]};
			FMT_B: begin
				o_imm = {{(`XLEN-13){sgn}}, i_instr[31], i_instr[7],
					i_instr[30:25], i_instr[11:8], 1'b0};	// halfword aligned
			end
			FMT_U: o_imm = {{(`XLEN-32){sgn}}, i_instr[31:12], 12'b0};
			FMT_J: begin
				o_imm = {{(`XLEN-21){sgn}}, i_instr[31], i_instr[19:12],
					i_instr[20], i_instr[30:21], 1'b0};
			end
			default: o_imm = '0;	// R format has no immediate
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`include "id_stage_config.svh"

`default_nettype none

module instr_decoder (
	input  wire logic [`ILEN-1:0]	i_instr,
	input  wire logic			i_valid,
	output id_pkg::id_ctrl_t		o_ctrl
);

	import id_pkg::*;

	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT  = 7'h20;	// SUB and SRA
	localparam logic [2:0] F3_JALR = 3'b000;

	logic [2:0]	f3;
	logic [6:0]	f7;
	logic		is_reg;	// OP rather than OP_IMM
	logic		legal;
	id_ctrl_t	dec;

	assign f3 = i_instr[`RNG_F3];
	assign f7 = i_instr[`RNG_F7];
	assign is_reg = (i_instr[`RNG_OP] == OPC_OP);

	always_comb begin
		dec = '0;
		dec.is_valid = 1'b1;
		legal = 1'b1;
		case (opcode_e'(i_instr[`RNG_OP]))
			OPC_LUI, OPC_AUIPC: begin
				dec.format = FMT_U;
				dec.alu_op = i_instr[5] ? ALU_LUI : ALU_AUIPC;	// bit 5 splits LUI from AUIPC
				dec.alu_src = 1'b1;
				dec.rf_wr = 1'b1;
			end
			OPC_JAL, OPC_JALR: begin
				dec.format = i_instr[3] ? FMT_J : FMT_I;	// bit 3 set only for JAL
				dec.alu_op = ALU_ADD;
				dec.alu_src = 1'b1;
				dec.is_branch = 1'b1;
				dec.rf_wr = 1'b1;
				legal = i_instr[3] || (f3 == F3_JALR);
			end
			OPC_BRANCH: begin
				dec.format = FMT_B;
				dec.is_branch = 1'b1;
				case (f3_branch_e'(f3))
					F3_BEQ: begin
						dec.alu_op = ALU_SUB;
						dec.branch_type = BR_BEQ;
					end
					F3_BNE: begin
						dec.alu_op = ALU_SUB;
						dec.branch_type = BR_BNE;
					end
					F3_BLT: begin
						dec.alu_op = ALU_SLT;
						dec.branch_type = BR_BLT;
					end
					F3_BGE: begin
						dec.alu_op = ALU_SLT;
						dec.branch_type = BR_BGE;
					end
					F3_BLTU: begin
						dec.alu_op = ALU_SLTU;
						dec.branch_type = BR_BLTU;
					end
					F3_BGEU: begin
						dec.alu_op = ALU_SLTU;
						dec.branch_type = BR_BGEU;
					end
					default: legal = 1'b0;	// 010 and 011 reserved
				endcase
			end
			OPC_LOAD: begin
				dec.format = FMT_I;
				dec.alu_op = ALU_ADD;
				dec.alu_src = 1'b1;
				dec.mem_rd = 1'b1;
				dec.rf_wr = 1'b1;
				case (f3_load_e'(f3))
					F3_LB:  dec.mem_size = MEM_BYTE;
					F3_LH:  dec.mem_size = MEM_HALF;
					F3_LW:  dec.mem_size = MEM_WORD;
					F3_LBU: begin
						dec.mem_size = MEM_BYTE;
						dec.mem_unsigned = 1'b1;
					end
					F3_LHU: begin
						dec.mem_size = MEM_HALF;
						dec.mem_unsigned = 1'b1;
					end
					default: legal = 1'b0;	// LD and LWU not supported
				endcase
			end
			OPC_STORE: begin
				dec.format = FMT_S;
				dec.alu_op = ALU_ADD;
				dec.alu_src = 1'b1;
				dec.mem_wr = 1'b1;
				case (f3_store_e'(f3))
					F3_SB: dec.mem_size = MEM_BYTE;
					F3_SH: dec.mem_size = MEM_HALF;
					F3_SW: dec.mem_size = MEM_WORD;
					default: legal = 1'b0;
				endcase
			end
			OPC_OP_IMM, OPC_OP: begin
				dec.format = is_reg ? FMT_R : FMT_I;
				dec.alu_src = !is_reg;
				dec.rf_wr = 1'b1;
				// funct7 must be clear except where it selects SUB or SRA
				legal = !is_reg || (f7 == F7_BASE);
				case (f3_alu_e'(f3))
					F3_ADD_SUB: begin
						dec.alu_op = (is_reg && (f7 == F7_ALT)) ? ALU_SUB : ALU_ADD;
						legal = !is_reg || (f7 == F7_BASE) || (f7 == F7_ALT);
					end
					F3_SLL: begin
						dec.alu_op = ALU_SLL;
						legal = (f7 == F7_BASE);	// shamt is 5 bits
					end
					F3_SR: begin
						dec.alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						legal = (f7 == F7_BASE) || (f7 == F7_ALT);
					end
					F3_SLT:  dec.alu_op = ALU_SLT;
					F3_SLTU: dec.alu_op = ALU_SLTU;
					F3_XOR:  dec.alu_op = ALU_XOR;
					F3_OR:   dec.alu_op = ALU_OR;
					F3_AND:  dec.alu_op = ALU_AND;
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;	// unknown opcode
		endcase
		if (dec.rf_wr) begin
			dec.rd_addr = i_instr[`RNG_RD];
		end
	end

	// flushed or illegal slots become the all-zero bubble
	assign o_ctrl = (i_valid && legal) ? dec : '0;

endmodule

`default_nettype wire

// ==== hdl/regfile_2r1w.sv ====
`include "id_stage_config.svh"

`default_nettype none

module regfile_2r1w (
	input  wire logic			clk,
	input  wire logic [`REG_AW-1:0]	i_raddr_a,
	input  wire logic [`REG_AW-1:0]	i_raddr_b,
	input  wire logic			i_wen,
	input  wire logic [`REG_AW-1:0]	i_waddr,
	input  wire logic [`XLEN-1:0]	i_wdata,
	output logic [`XLEN-1:0]		o_rdata_a,
	output logic [`XLEN-1:0]		o_rdata_b
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (i_wen && (i_waddr != '0)) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// no bypass, same-edge write shows up next cycle
	assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== id_stage.f ====
+incdir+include
hdl/id_pkg.sv
hdl/regfile_2r1w.sv
hdl/imm_gen.sv
hdl/instr_decoder.sv
hdl/id_stage.sv
test/id_stage_assertions.sv
test/tb_id_stage.sv

// ==== include/id_stage_config.svh ====
`ifndef ID_STAGE_CONFIG_SVH
`define ID_STAGE_CONFIG_SVH

// datapath widths
`define XLEN		64	// register and data width
`define ILEN		32	// instruction width

// register file geometry
`define REG_AW		5
`define NUM_REGS	32

// instruction field ranges
`define RNG_OP		6:0
`define RNG_RD		11:7
`define RNG_F3		14:12
`define RNG_RS1		19:15
`define RNG_RS2		24:20
`define RNG_F7		31:25

`endif

// ==== test/id_stage_assertions.sv ====
`default_nettype none

module id_stage_assertions (
	input wire logic		clk,
	input wire logic		rst_n,
	input wire logic		i_ready,
	input wire logic		i_branch_taken,
	input wire logic		i_jump_taken,
	input wire id_pkg::id_ctrl_t	i_ctrl
);

	timeunit 1ns;
	timeprecision 1ps;

	// back-pressure freezes the stage register
	assert property (@(posedge clk) disable iff (!rst_n) !i_ready |=> $stable(i_ctrl))
		else $error("stage register changed while stalled");

	assert property (@(posedge clk) disable iff (!rst_n)
		(i_ready && (i_branch_taken || i_jump_taken)) |=> !i_ctrl.is_valid)
		else $error("redirect did not load a bubble");

	assert property (@(posedge clk) !rst_n |-> !i_ctrl.is_valid)
		else $error("valid record during reset");

	// a bubble must not write anything
	assert property (@(posedge clk) disable iff (!rst_n)
		!i_ctrl.is_valid |-> !(i_ctrl.rf_wr || i_ctrl.mem_rd || i_ctrl.mem_wr))
		else $error("bubble carries an active write or memory control");

endmodule

`default_nettype wire

// ==== test/tb_id_stage.sv ====
`default_nettype none

module tb_id_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import id_pkg::*;

	localparam int CW = $bits(id_ctrl_t);
	localparam int WAIT_LIMIT = 50;	// cycles before a wait gives up

	logic		clk = 1'b0;
	logic		rst_n;
	logic [31:0]	i_if_instr;
	logic		i_if_valid;
	logic [63:0]	i_if_pc;
	logic		i_ex_ready;
	logic		i_ex_branch_taken;
	logic		i_ex_jump_taken;
	logic		i_wb_wr_en;
	logic [4:0]	i_wb_wr_addr;
	logic [63:0]	i_wb_wr_data;
	logic		o_id_ready;
	id_ctrl_t	o_id_ctrl;
	logic [63:0]	shadow [32] = '{default: '0};	// expected register contents
	logic		reported = 1'b0;

	id_stage i_dut (
		.clk			(clk),
		.rst_n			(rst_n),
		.i_if_instr		(i_if_instr),
		.i_if_valid		(i_if_valid),
		.i_if_pc		(i_if_pc),
		.i_ex_ready		(i_ex_ready),
		.i_ex_branch_taken	(i_ex_branch_taken),
		.i_ex_jump_taken	(i_ex_jump_taken),
		.i_wb_wr_en		(i_wb_wr_en),
		.i_wb_wr_addr		(i_wb_wr_addr),
		.i_wb_wr_data		(i_wb_wr_data),
		.o_id_ready		(o_id_ready),
		.o_id_ctrl		(o_id_ctrl)
	);

	bind id_stage id_stage_assertions i_chk (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_ready	(o_id_ready),
		.i_branch_taken	(i_ex_branch_taken),
		.i_jump_taken	(i_ex_jump_taken),
		.i_ctrl		(o_id_ctrl)
	);

	always #10 clk = ~clk;	// 20 ns period

	task automatic abort_run();
		reported = 1'b1;
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare(input string name, input logic [CW-1:0] exp, input logic [CW-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	// random register fields around the given opcode and funct bits
	function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
			input logic [6:0] opc);
		logic [31:0] r;
		r = $urandom;
		return {f7, r[24:20], r[19:15], f3, r[11:7], opc};
	endfunction

	function automatic logic [63:0] expected_imm(input logic [31:0] ins, input format_e f);
		case (f)
			FMT_I: return 64'($signed(ins[31:20]));
			FMT_S: return 64'($signed({ins[31:25], ins[11:7]}));
			FMT_B: return 64'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
			FMT_U: return 64'($signed({ins[31:12], 12'h000}));
			FMT_J: return 64'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
			default: return 64'd0;
		endcase
	endfunction

	function automatic id_ctrl_t expected_ctrl(input format_e f, input alu_op_e op,
			input logic src, input logic wr);
		id_ctrl_t e;
		e = '0;
		e.is_valid = 1'b1;
		e.format = f;
		e.alu_op = op;
		e.alu_src = src;
		e.rf_wr = wr;
		return e;
	endfunction

	task automatic drive_instr(input logic [31:0] ins, input logic [63:0] pc, input logic valid,
			input logic br, input logic jmp);
		int waited;
		@(negedge clk);
		i_if_instr = ins;
		i_if_pc = pc;
		i_if_valid = valid;
		i_ex_branch_taken = br;
		i_ex_jump_taken = jmp;
		i_ex_ready = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("timeout: the stage never signalled ready");
				abort_run();
			end
		end while (!o_id_ready);
		@(negedge clk);	// record settled half a cycle after the load edge
	endtask

	// fills the data fields of the expected record, then runs one instruction
	task automatic decode_check(input string name, input logic [31:0] ins, input id_ctrl_t e);
		logic [63:0] pc;
		pc = {$urandom, $urandom};
		if (e.is_valid) begin
			e.rd_addr = e.rf_wr ? ins[11:7] : 5'd0;
			e.pc = pc;
			e.rs1_data = shadow[ins[19:15]];
			e.rs2_data = shadow[ins[24:20]];
			e.imm = expected_imm(ins, e.format);
		end
		drive_instr(ins, pc, 1'b1, 1'b0, 1'b0);
		compare(name, e, o_id_ctrl);
	endtask

	task automatic reset_state();
		@(negedge clk);
		compare("reset", '0, o_id_ctrl);
	endtask

	task automatic regfile_readback();
		logic [63:0] v;
		logic [4:0] a;
		for (int i = 0; i < 48; i++) begin
			a = (i < 32) ? 5'(i) : 5'($urandom);	// every register, then random ones
			v = {$urandom, $urandom};
			@(negedge clk);
			i_wb_wr_en = 1'b1;
			i_wb_wr_addr = a;
			i_wb_wr_data = v;
			if (a != 5'd0) begin
				shadow[a] = v;
			end
		end
		@(negedge clk);
		i_wb_wr_en = 1'b0;
		for (int r = 0; r < 32; r++) begin
			decode_check($sformatf("regfile x%0d", r),
				{7'h00, 5'(31 - r), 5'(r), 3'b000, 5'($urandom), OPC_OP},
				expected_ctrl(FMT_R, ALU_ADD, 1'b0, 1'b1));
		end
	endtask

	task automatic decode_table();
		id_ctrl_t e;
		logic [2:0] f3;
		logic alt;
		alu_op_e op;
		alu_op_e alu_tab [8];
		alu_tab = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
		decode_check("lui", encode(7'($urandom), 3'($urandom), OPC_LUI),
			expected_ctrl(FMT_U, ALU_LUI, 1'b1, 1'b1));
		decode_check("auipc", encode(7'($urandom), 3'($urandom), OPC_AUIPC),
			expected_ctrl(FMT_U, ALU_AUIPC, 1'b1, 1'b1));
		e = expected_ctrl(FMT_J, ALU_ADD, 1'b1, 1'b1);
		e.is_branch = 1'b1;
		decode_check("jal", encode(7'($urandom), 3'($urandom), OPC_JAL), e);
		e.format = FMT_I;
		decode_check("jalr", encode(7'($urandom), 3'b000, OPC_JALR), e);
		for (int i = 0; i < 6; i++) begin
			f3 = (i < 2) ? 3'(i) : 3'(i + 2);	// skips the reserved 010 and 011
			op = (i < 2) ? ALU_SUB : (i < 4) ? ALU_SLT : ALU_SLTU;
			e = expected_ctrl(FMT_B, op, 1'b0, 1'b0);
			e.is_branch = 1'b1;
			e.branch_type = branch_e'(i + 1);
			decode_check($sformatf("branch f3=%0d", f3), encode(7'($urandom), f3, OPC_BRANCH), e);
		end
		for (int i = 0; i < 8; i++) begin
			f3 = 3'(i);
			if (f3 == 3'b011 || f3 >= 3'b110) begin
				continue;
			end
			e = expected_ctrl(FMT_I, ALU_ADD, 1'b1, 1'b1);
			e.mem_rd = 1'b1;
			e.mem_size = mem_size_e'(f3[1:0]);	// low bits give the size
			e.mem_unsigned = f3[2];
			decode_check($sformatf("load f3=%0d", f3), encode(7'($urandom), f3, OPC_LOAD), e);
			if (f3 > 3'b010) begin
				continue;
			end
			e = expected_ctrl(FMT_S, ALU_ADD, 1'b1, 1'b0);
			e.mem_wr = 1'b1;
			e.mem_size = mem_size_e'(f3[1:0]);
			decode_check($sformatf("store f3=%0d", f3), encode(7'($urandom), f3, OPC_STORE), e);
		end
		for (int i = 0; i < 16; i++) begin
			f3 = 3'(i);
			alt = (i >= 8);	// second pass uses funct7 0x20
			op = alu_tab[f3];
			if (alt && f3 == 3'b000) begin
				op = ALU_SUB;
			end
			if (alt && f3 == 3'b101) begin
				op = ALU_SRA;
			end
			if (!alt || f3 == 3'b000 || f3 == 3'b101) begin
				decode_check($sformatf("op f3=%0d alt=%0d", f3, alt),
					encode(alt ? 7'h20 : 7'h00, f3, OPC_OP),
					expected_ctrl(FMT_R, op, 1'b0, 1'b1));
			end
			if (!alt) begin
				decode_check($sformatf("op_imm f3=%0d", f3),
					encode((f3[1:0] == 2'b01) ? 7'h00 : 7'($urandom), f3, OPC_OP_IMM),
					expected_ctrl(FMT_I, op, 1'b1, 1'b1));
			end else if (f3 == 3'b101) begin
				decode_check("srai", encode(7'h20, f3, OPC_OP_IMM),
					expected_ctrl(FMT_I, ALU_SRA, 1'b1, 1'b1));
			end
		end
	endtask

	task automatic illegal_encodings();
		decode_check("bad opcode", encode(7'h00, 3'b000, 7'b1111111), '0);
		decode_check("bad branch f3", encode(7'h00, 3'b010, OPC_BRANCH), '0);
		decode_check("bad load f3", encode(7'h00, 3'b011, OPC_LOAD), '0);
		decode_check("bad store f3", encode(7'h00, 3'b100, OPC_STORE), '0);
		decode_check("bad op f7", encode(7'h01, 3'b000, OPC_OP), '0);
		decode_check("bad op xor f7", encode(7'h20, 3'b100, OPC_OP), '0);
		decode_check("bad slli f7", encode(7'h20, 3'b001, OPC_OP_IMM), '0);
		decode_check("bad srli f7", encode(7'h01, 3'b101, OPC_OP_IMM), '0);
		decode_check("bad jalr f3", encode(7'h00, 3'b001, OPC_JALR), '0);
	endtask

	task automatic flush_bubbles();
		logic [31:0] ins;
		ins = encode(7'h00, 3'b000, OPC_OP);
		drive_instr(ins, 64'h1000, 1'b1, 1'b1, 1'b0);
		compare("flush branch", '0, o_id_ctrl);
		drive_instr(ins, 64'h1004, 1'b1, 1'b0, 1'b1);
		compare("flush jump", '0, o_id_ctrl);
		drive_instr(ins, 64'h1008, 1'b0, 1'b0, 1'b0);
		compare("fetch invalid", '0, o_id_ctrl);
	endtask

	task automatic stall_hold();
		id_ctrl_t held;
		decode_check("stall setup", encode(7'h00, 3'b100, OPC_OP),
			expected_ctrl(FMT_R, ALU_XOR, 1'b0, 1'b1));
		held = o_id_ctrl;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			compare("stall hold", held, o_id_ctrl);
			i_ex_ready = 1'b0;
			i_if_instr = encode(7'h00, 3'b111, OPC_OP);	// fetch changes underneath
			i_if_pc = {$urandom, $urandom};
			@(posedge clk);
			compare("stall ready", '0, CW'(o_id_ready));
		end
		@(negedge clk);
		compare("stall hold", held, o_id_ctrl);
		decode_check("stall release", encode(7'h00, 3'b110, OPC_OP),
			expected_ctrl(FMT_R, ALU_OR, 1'b0, 1'b1));
	endtask

	initial begin
		void'($urandom(97));
		rst_n = 1'b1;
		i_if_instr = '0;
		i_if_valid = 1'b0;
		i_if_pc = '0;
		i_ex_ready = 1'b0;
		i_ex_branch_taken = 1'b0;
		i_ex_jump_taken = 1'b0;
		i_wb_wr_en = 1'b0;
		i_wb_wr_addr = '0;
		i_wb_wr_data = '0;
		#1 rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_state();
		regfile_readback();
		decode_table();
		illegal_encodings();
		flush_bubbles();
		stall_hold();
		reported = 1'b1;
		$display(">>> PASS");
		$finish;
	end

	// run ended by an assertion stop
	final begin
		if (!reported) begin
			$display(">>> FAIL");
		end
	end

endmodule

`default_nettype wire
